//--- hw/rr_pkg.sv
`default_nettype none

package rr_pkg;

  ////////////////////////////////////////
  // channel payloads
  ////////////////////////////////////////
  // register channel, full word
  localparam int REG_W = 32;
  // dma channel, half word
  localparam int DMA_W = 16;

  typedef logic [REG_W-1:0] reg_word_t;
  typedef logic [DMA_W-1:0] dma_word_t;

  // bit 0 register channel, bit 1 dma channel
  localparam int NUM_CH = 2;
  typedef logic [NUM_CH-1:0] chan_map_t;

  ////////////////////////////////////////
  // trace storage
  ////////////////////////////////////////
  localparam int GAP_W = 8;
  typedef logic [GAP_W-1:0] gap_t;
  // idle count at which an empty entry is forced
  localparam int GAP_MAX = (1 << GAP_W) - 1;

  localparam int TRACE_DEPTH = 64;
  localparam int PTR_W = $clog2(TRACE_DEPTH);
  // one extra bit so a full buffer is representable
  typedef logic [PTR_W:0] count_t;

  // 58 bits: gap, valid bitmap, then both payloads
  typedef struct packed {
    gap_t      gap;
    chan_map_t map;
    reg_word_t reg_data;
    dma_word_t dma_data;
  } trace_entry_t;

  typedef enum logic [1:0] {
    MODE_IDLE   = 2'd0,
    MODE_RECORD = 2'd1,
    MODE_REPLAY = 2'd2
  } rr_mode_t;

endpackage

`default_nettype wire

//--- hw/rr_mode_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rr_mode_fsm import rr_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     i_rec_start,
  input  logic     i_rep_start,
  input  logic     i_stop,
  input  logic     i_any_valid,
  input  logic     i_saturated,
  input  logic     i_zero,
  input  logic     i_empty_read,
  output rr_mode_t o_mode,
  output logic     o_write,
  output logic     o_fire,
  output logic     o_rewind,
  output logic     o_timer_clear,
  output logic     o_timer_load,
  output logic     o_replay_done
);

  rr_mode_t mode_q;
  rr_mode_t mode_d;
  // set once the timer holds the gap of the entry at the read pointer
  logic     loaded_q;
  logic     in_rec;
  logic     in_rep;
  logic     rep_go;
  logic     rep_end;

  assign in_rec = (mode_q == MODE_RECORD);
  assign in_rep = (mode_q == MODE_REPLAY);

  // replay is only launched from idle, other pulses win
  assign rep_go = (mode_q == MODE_IDLE) & i_rep_start & ~i_stop & ~i_rec_start;
  // nothing pending and the read pointer caught up with the count
  assign rep_end = in_rep & ~loaded_q & i_empty_read;

  ////////////////////////////////////////
  // record and replay decisions
  ////////////////////////////////////////
  // a tap strobe or a saturated gap makes an entry
  assign o_write       = in_rec & (i_any_valid | i_saturated);
  assign o_timer_clear = o_write | i_rec_start;
  assign o_rewind      = rep_go;
  // load the next gap; a zero gap fires on this very cycle
  assign o_timer_load  = in_rep & ~loaded_q & ~i_empty_read;
  assign o_fire        = in_rep & ~rep_end & i_zero;
  assign o_replay_done = rep_end;
  assign o_mode        = mode_q;

  // stop first, then record start, then replay start
  always_comb begin
    mode_d = mode_q;
    if (i_stop) begin
      mode_d = MODE_IDLE;
    end else if (i_rec_start) begin
      mode_d = MODE_RECORD;
    end else if (rep_go) begin
      mode_d = MODE_REPLAY;
    end else if (rep_end) begin
      mode_d = MODE_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode_q   <= MODE_IDLE;
      loaded_q <= 1'b0;
    end else begin
      mode_q <= mode_d;
      // a fire consumes the loaded gap, even if loaded this cycle
      if (!in_rep || o_fire) begin
        loaded_q <= 1'b0;
      end else if (o_timer_load) begin
        loaded_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/rr_gap_timer.sv
`timescale 1ns/1ps
`default_nettype none

module rr_gap_timer import rr_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  rr_mode_t i_mode,
  input  logic     i_clear,
  input  logic     i_load,
  input  gap_t     i_load_gap,
  output gap_t     o_gap,
  output logic     o_saturated,
  output logic     o_zero
);

  gap_t cnt_q;

  // record: idle cycles since last write, stops at GAP_MAX
  // replay: cycles left until the loaded entry fires
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q <= '0;
    end else if (i_clear) begin
      cnt_q <= '0;
    end else if (i_load) begin
      // load cycle itself counts as one cycle of the gap
      cnt_q <= i_load_gap - gap_t'(i_load_gap != '0);
    end else if (i_mode == MODE_RECORD && !o_saturated) begin
      cnt_q <= cnt_q + gap_t'(1);
    end else if (i_mode == MODE_REPLAY && cnt_q != '0) begin
      cnt_q <= cnt_q - gap_t'(1);
    end
  end

  assign o_gap       = cnt_q;
  assign o_saturated = (cnt_q == gap_t'(GAP_MAX));
  // zero gap on the load cycle bypasses the counter
  assign o_zero      = i_load ? (i_load_gap == '0) : (cnt_q == '0);

endmodule

`default_nettype wire

//--- hw/rr_channel_tap.sv
`timescale 1ns/1ps
`default_nettype none

module rr_channel_tap import rr_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  rr_mode_t i_mode,
  input  logic     i_valid,
  input  payload_t i_data,
  input  logic     i_fire,
  input  logic     i_replay_valid,
  input  payload_t i_replay_data,
  output logic     o_valid,
  output payload_t o_data,
  output logic     o_log_valid,
  output payload_t o_log_data
);

  logic     valid_q;
  payload_t data_q;

  // host strobe passes through, replay takes over the stage
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= 1'b0;
    end else if (i_mode == MODE_REPLAY) begin
      valid_q <= i_fire & i_replay_valid;
    end else begin
      valid_q <= i_valid;
    end
  end

  // payload stage, host input ignored during replay
  always_ff @(posedge clk) begin
    if (i_mode != MODE_REPLAY) begin
      data_q <= i_data;
    end else if (i_fire) begin
      data_q <= i_replay_data;
    end
  end

  assign o_valid     = valid_q;
  assign o_data      = data_q;
  // same cycle the user side sees it
  assign o_log_valid = valid_q & (i_mode == MODE_RECORD);
  assign o_log_data  = data_q;

endmodule

`default_nettype wire

//--- hw/rr_trace_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rr_trace_buffer import rr_pkg::*; (
  input  logic         clk,
  input  logic         rstn,
  input  logic         i_rec_start,
  input  logic         i_write,
  input  gap_t         i_gap,
  input  chan_map_t    i_map,
  input  reg_word_t    i_reg_data,
  input  dma_word_t    i_dma_data,
  input  logic         i_fire,
  input  logic         i_rewind,
  output trace_entry_t o_entry,
  output logic         o_empty_read,
  output count_t       o_entry_count,
  output logic         o_overflow
);

  trace_entry_t             mem_q [TRACE_DEPTH];
  trace_entry_t             wr_entry;
  count_t                   count_q;
  // read pointer wide enough to reach the count of a full buffer
  count_t                   rptr_q;
  logic [PTR_W-1:0]         wptr;
  logic                     full;
  logic                     wr_en;
  logic                     overflow_q;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////
  // entries are never removed, so count tracks the write pointer
  assign wptr  = count_q[PTR_W-1:0];
  assign full  = (count_q == count_t'(TRACE_DEPTH));
  // a restart drops a write on the same cycle
  assign wr_en = i_write & ~full & ~i_rec_start;

  assign wr_entry.gap      = i_gap;
  assign wr_entry.map      = i_map;
  assign wr_entry.reg_data = i_reg_data;
  assign wr_entry.dma_data = i_dma_data;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wptr] <= wr_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else if (i_rec_start) begin
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else if (i_write) begin
      // sticky until the next record start
      if (full) begin
        overflow_q <= 1'b1;
      end else begin
        count_q <= count_q + count_t'(1);
      end
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rptr_q <= '0;
    end else if (i_rewind) begin
      rptr_q <= '0;
    end else if (i_fire) begin
      rptr_q <= rptr_q + count_t'(1);
    end
  end

  // combinational read of the entry due next
  assign o_entry       = mem_q[rptr_q[PTR_W-1:0]];
  assign o_empty_read  = (rptr_q == count_q);
  assign o_entry_count = count_q;
  assign o_overflow    = overflow_q;

endmodule

`default_nettype wire

//--- hw/rr_trace_top.sv
`timescale 1ns/1ps
`default_nettype none

module rr_trace_top import rr_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      i_rec_start,
  input  logic      i_rep_start,
  input  logic      i_stop,
  input  logic      i_reg_valid,
  input  reg_word_t i_reg_data,
  input  logic      i_dma_valid,
  input  dma_word_t i_dma_data,
  output logic      o_reg_valid,
  output reg_word_t o_reg_data,
  output logic      o_dma_valid,
  output dma_word_t o_dma_data,
  output rr_mode_t  o_mode,
  output count_t    o_entry_count,
  output logic      o_overflow,
  output logic      o_replay_done
);

  logic         reg_log_valid;
  logic         dma_log_valid;
  reg_word_t    reg_log_data;
  dma_word_t    dma_log_data;
  logic         any_valid;
  logic         write;
  logic         fire;
  logic         rewind;
  logic         timer_clear;
  logic         timer_load;
  logic         saturated;
  logic         zero;
  logic         empty_read;
  gap_t         gap;
  trace_entry_t rd_entry;

  // either channel strobing makes an entry
  assign any_valid = reg_log_valid | dma_log_valid;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////
  rr_mode_fsm fsm (
    .clk(clk), .rstn(rstn),
    .i_rec_start(i_rec_start), .i_rep_start(i_rep_start), .i_stop(i_stop),
    .i_any_valid(any_valid), .i_saturated(saturated), .i_zero(zero),
    .i_empty_read(empty_read), .o_mode(o_mode), .o_write(write), .o_fire(fire),
    .o_rewind(rewind), .o_timer_clear(timer_clear), .o_timer_load(timer_load),
    .o_replay_done(o_replay_done)
  );

  rr_gap_timer timer (
    .clk(clk), .rstn(rstn), .i_mode(o_mode),
    .i_clear(timer_clear), .i_load(timer_load), .i_load_gap(rd_entry.gap),
    .o_gap(gap), .o_saturated(saturated), .o_zero(zero)
  );

  ////////////////////////////////////////
  // channels, map bit 0 reg, bit 1 dma
  ////////////////////////////////////////
  rr_channel_tap #(.payload_t(reg_word_t)) reg_tap (
    .clk(clk), .rstn(rstn), .i_mode(o_mode),
    .i_valid(i_reg_valid), .i_data(i_reg_data), .i_fire(fire),
    .i_replay_valid(rd_entry.map[0]), .i_replay_data(rd_entry.reg_data),
    .o_valid(o_reg_valid), .o_data(o_reg_data),
    .o_log_valid(reg_log_valid), .o_log_data(reg_log_data)
  );

  rr_channel_tap #(.payload_t(dma_word_t)) dma_tap (
    .clk(clk), .rstn(rstn), .i_mode(o_mode),
    .i_valid(i_dma_valid), .i_data(i_dma_data), .i_fire(fire),
    .i_replay_valid(rd_entry.map[1]), .i_replay_data(rd_entry.dma_data),
    .o_valid(o_dma_valid), .o_data(o_dma_data),
    .o_log_valid(dma_log_valid), .o_log_data(dma_log_data)
  );

  rr_trace_buffer buffer (
    .clk(clk), .rstn(rstn), .i_rec_start(i_rec_start), .i_write(write),
    .i_gap(gap), .i_map({dma_log_valid, reg_log_valid}),
    .i_reg_data(reg_log_data), .i_dma_data(dma_log_data),
    .i_fire(fire), .i_rewind(rewind), .o_entry(rd_entry), .o_empty_read(empty_read),
    .o_entry_count(o_entry_count), .o_overflow(o_overflow)
  );

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic o_clk
);

  // 10 ns period
  initial o_clk = 1'b0;
  always #5 o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- test/rr_trace_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rr_trace_assert import rr_pkg::*; (
  input logic     clk,
  input logic     rstn,
  input rr_mode_t i_mode,
  input logic     i_write,
  input logic     i_fire,
  input logic     i_empty_read,
  input logic     i_replay_done
);

  // done is a single cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    i_replay_done |=> !i_replay_done)
    else $error("replay done held longer than one cycle");

  // record and replay never overlap
  a_write_fire: assert property (@(posedge clk) disable iff (!rstn)
    !(i_write && i_fire))
    else $error("write and fire asserted together");

  // a fire only in replay, and always with a stored entry left to read
  a_fire_mode: assert property (@(posedge clk) disable iff (!rstn)
    i_fire |-> (i_mode == MODE_REPLAY) && !i_empty_read)
    else $error("fire outside replay mode or past the last entry");

endmodule

bind rr_mode_fsm rr_trace_assert fsm_assert (
  .clk(clk), .rstn(rstn), .i_mode(o_mode), .i_write(o_write),
  .i_fire(o_fire), .i_empty_read(i_empty_read), .i_replay_done(o_replay_done)
);

`default_nettype wire

//--- test/tb_rr_trace.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rr_trace import rr_pkg::*; ();

  localparam int TEST_CYCLES = 2000;
  localparam int DONE_LIMIT = 2000;
  localparam int PH_NONE = 0;
  localparam int PH_PASS = 1;
  localparam int PH_REPLAY = 2;

  logic      clk;
  logic      rstn;
  logic      i_rec_start;
  logic      i_rep_start;
  logic      i_stop;
  logic      i_reg_valid;
  reg_word_t i_reg_data;
  logic      i_dma_valid;
  dma_word_t i_dma_data;
  logic      o_reg_valid;
  reg_word_t o_reg_data;
  logic      o_dma_valid;
  dma_word_t o_dma_data;
  rr_mode_t  o_mode;
  count_t    o_entry_count;
  logic      o_overflow;
  logic      o_replay_done;

  logic [31:0] lfsr_q;
  int          cyc;
  int          phase;
  int          val_err;
  int          oth_err;
  int          done_cnt;
  int          seen;
  bit          based;
  int          base_cyc;
  int          last_w;
  int          exp_entries;
  logic        prev_reg_v;
  logic        prev_dma_v;
  reg_word_t   prev_reg_d;
  dma_word_t   prev_dma_d;

  // recorded events, one slot per strobe cycle
  int        ev_cyc [$];
  chan_map_t ev_map [$];
  reg_word_t ev_reg [$];
  dma_word_t ev_dma [$];

  tb_clkgen clkgen (.o_clk(clk));

  rr_trace_top uut (
    .clk(clk), .rstn(rstn), .i_rec_start(i_rec_start), .i_rep_start(i_rep_start),
    .i_stop(i_stop), .i_reg_valid(i_reg_valid), .i_reg_data(i_reg_data),
    .i_dma_valid(i_dma_valid), .i_dma_data(i_dma_data),
    .o_reg_valid(o_reg_valid), .o_reg_data(o_reg_data),
    .o_dma_valid(o_dma_valid), .o_dma_data(o_dma_data), .o_mode(o_mode),
    .o_entry_count(o_entry_count), .o_overflow(o_overflow),
    .o_replay_done(o_replay_done)
  );

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // event due at a replay offset relative to the first event, or -1
  function automatic int event_at(input int rel);
    for (int i = 0; i < ev_cyc.size(); i++) begin
      if (ev_cyc[i] - ev_cyc[0] == rel) return i;
    end
    return -1;
  endfunction

  task automatic check_reg(input string name, input reg_word_t got, input reg_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
      val_err++;
    end
  endtask

  task automatic check_dma(input string name, input dma_word_t got, input dma_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
      val_err++;
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %0d exp %0d", $time, name, got, exp);
      val_err++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
      val_err++;
    end
  endtask

  task automatic check_mode(input string name, input rr_mode_t got, input rr_mode_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %0d exp %0d", $time, name, got, exp);
      val_err++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic zero_inputs();
    i_reg_valid = 1'b0;
    i_dma_valid = 1'b0;
    i_reg_data  = '0;
    i_dma_data  = '0;
  endtask

  // a strobe driven now is written one cycle later in record mode
  task automatic drive_random(input bit force_reg, input bit rec);
    logic [31:0] v;
    int          w;
    take_bits(1, v);
    i_reg_valid = v[0] | force_reg;
    take_bits(1, v);
    i_dma_valid = v[0];
    take_bits(32, v);
    i_reg_data = v;
    take_bits(16, v);
    i_dma_data = v[15:0];
    if (rec && (i_reg_valid || i_dma_valid)) begin
      w = cyc + 1;
      // one empty entry for every full gap in between
      exp_entries += (w - last_w - 1) / (GAP_MAX + 1);
      exp_entries++;
      last_w = w;
      ev_cyc.push_back(cyc);
      ev_map.push_back({i_dma_valid, i_reg_valid});
      ev_reg.push_back(i_reg_data);
      ev_dma.push_back(i_dma_data);
    end
  endtask

  task automatic record_trace(input int n, input bit force_reg, input int gap_at);
    int exp_cnt;
    ev_cyc.delete();
    ev_map.delete();
    ev_reg.delete();
    ev_dma.delete();
    @(posedge clk);
    #1;
    zero_inputs();
    i_rec_start = 1'b1;
    last_w = cyc;
    exp_entries = 0;
    @(posedge clk);
    #1;
    i_rec_start = 1'b0;
    for (int i = 0; i < n; i++) begin
      if (i == gap_at) begin
        repeat (600) begin
          @(posedge clk);
          #1;
          zero_inputs();
        end
      end
      @(posedge clk);
      #1;
      drive_random(force_reg, 1'b1);
    end
    @(posedge clk);
    #1;
    zero_inputs();
    @(posedge clk);
    #1;
    i_stop = 1'b1;
    exp_entries += (cyc - last_w) / (GAP_MAX + 1);
    @(posedge clk);
    #1;
    i_stop = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    exp_cnt = (exp_entries > TRACE_DEPTH) ? TRACE_DEPTH : exp_entries;
    check_count("o_entry_count", o_entry_count, count_t'(exp_cnt));
    check_bit("o_overflow", o_overflow, exp_entries > TRACE_DEPTH);
    check_mode("o_mode", o_mode, MODE_IDLE);
  endtask

  task automatic replay_trace();
    int n;
    @(posedge clk);
    #1;
    zero_inputs();
    i_rep_start = 1'b1;
    phase = PH_REPLAY;
    based = 1'b0;
    seen = 0;
    done_cnt = 0;
    @(posedge clk);
    #1;
    i_rep_start = 1'b0;
    n = 0;
    // host traffic during replay must not reach the user side
    while (done_cnt == 0 && n < DONE_LIMIT) begin
      drive_random(1'b0, 1'b0);
      @(posedge clk);
      #1;
      n++;
    end
    zero_inputs();
    phase = PH_NONE;
    if (done_cnt == 0) begin
      $display("replay did not finish within %0d cycles", DONE_LIMIT);
      oth_err++;
    end
    repeat (3) @(posedge clk);
    #1;
    check_count("replay done pulses", count_t'(done_cnt), count_t'(1));
    check_mode("o_mode", o_mode, MODE_IDLE);
    check_count("replayed events", count_t'(seen), count_t'(ev_cyc.size()));
    phase = PH_PASS;
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////
  always @(posedge clk) begin
    cyc        <= cyc + 1;
    prev_reg_v <= i_reg_valid;
    prev_dma_v <= i_dma_valid;
    prev_reg_d <= i_reg_data;
    prev_dma_d <= i_dma_data;
  end

  // outputs settled half a cycle after the edge
  always @(negedge clk) begin
    int idx;
    if (rstn) begin
      if (o_replay_done) done_cnt++;
      if (phase == PH_PASS) begin
        check_bit("o_reg_valid", o_reg_valid, prev_reg_v);
        check_bit("o_dma_valid", o_dma_valid, prev_dma_v);
        if (prev_reg_v) check_reg("o_reg_data", o_reg_data, prev_reg_d);
        if (prev_dma_v) check_dma("o_dma_data", o_dma_data, prev_dma_d);
      end else if (phase == PH_REPLAY) begin
        // spacing is checked relative to the first replayed strobe
        if (!based && (o_reg_valid || o_dma_valid)) begin
          based = 1'b1;
          base_cyc = cyc;
        end
        if (based) begin
          idx = event_at(cyc - base_cyc);
          if (idx >= 0) begin
            check_bit("o_reg_valid", o_reg_valid, ev_map[idx][0]);
            check_bit("o_dma_valid", o_dma_valid, ev_map[idx][1]);
            if (ev_map[idx][0]) check_reg("o_reg_data", o_reg_data, ev_reg[idx]);
            if (ev_map[idx][1]) check_dma("o_dma_data", o_dma_data, ev_dma[idx]);
            seen++;
          end else begin
            check_bit("o_reg_valid", o_reg_valid, 1'b0);
            check_bit("o_dma_valid", o_dma_valid, 1'b0);
          end
        end
      end
    end
  end

  // worst case run length plus margin
  initial begin
    #((TEST_CYCLES + 2000) * 10);
    $display("watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    rstn = 1'b0;
    i_rec_start = 1'b0;
    i_rep_start = 1'b0;
    i_stop = 1'b0;
    zero_inputs();
    lfsr_q = 32'h549a;
    cyc = 0;
    phase = PH_NONE;
    val_err = 0;
    oth_err = 0;
    done_cnt = 0;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    check_mode("o_mode", o_mode, MODE_IDLE);
    check_bit("o_reg_valid", o_reg_valid, 1'b0);
    check_bit("o_dma_valid", o_dma_valid, 1'b0);
    check_bit("o_replay_done", o_replay_done, 1'b0);
    check_bit("o_overflow", o_overflow, 1'b0);

    // idle pass-through
    phase = PH_PASS;
    repeat (40) begin
      @(posedge clk);
      #1;
      drive_random(1'b0, 1'b0);
    end
    @(posedge clk);
    #1;
    zero_inputs();
    check_count("o_entry_count", o_entry_count, count_t'(0));

    // plain record and replay, then one with a long idle stretch
    record_trace(40, 1'b0, -1);
    replay_trace();
    record_trace(30, 1'b0, 15);
    replay_trace();

    // overflow stays until the next record start
    record_trace(80, 1'b1, -1);
    repeat (20) @(posedge clk);
    #1;
    check_bit("o_overflow", o_overflow, 1'b1);
    record_trace(0, 1'b0, -1);
    replay_trace();

    $display("errors: value %0d, other %0d", val_err, oth_err);
    if (val_err + oth_err == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hw/rr_pkg.sv
hw/rr_mode_fsm.sv
hw/rr_gap_timer.sv
hw/rr_channel_tap.sv
hw/rr_trace_buffer.sv
hw/rr_trace_top.sv
test/tb_clkgen.sv
test/rr_trace_assert.sv
test/tb_rr_trace.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 -f all.f --top-module tb_rr_trace -o sim_rr_trace

./obj_dir/sim_rr_trace 2>&1 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
  exit 0
else
  echo "simulation did not report a pass"
  exit 1
fi
